/* run.sh */
#!/usr/bin/env bash
# builds the cpu testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb \
    -f sources.f -Mdir obj_dir -o cpuTbSim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/cpuTbSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* sim/cpuTb.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

module cpuTb;
    localparam int ProgLen     = 200;    // last slot holds the self-jump
    localparam int MemWords    = 512;    // 0x000-0x7ff
    localparam int DataBase    = 256;    // word index of 0x400
    localparam int RunTimeout  = 20000;
    localparam int DrainCycles = 16;

    localparam int kAddu  = 0;
    localparam int kSubu  = 1;
    localparam int kAnd   = 2;
    localparam int kOr    = 3;
    localparam int kXor   = 4;
    localparam int kSlt   = 5;
    localparam int kSll   = 6;
    localparam int kAddiu = 7;
    localparam int kOri   = 8;
    localparam int kLui   = 9;
    localparam int kLw    = 10;
    localparam int kLb    = 11;
    localparam int kSw    = 12;
    localparam int kSb    = 13;
    localparam int kBeq   = 14;
    localparam int kBne   = 15;
    localparam int kJ     = 16;
    localparam int kCount = 17;

    logic               clk;
    logic               reset;
    logic               memEn;
    logic [3:0]         memWen;
    logic [`XLEN-1:0]   memAddr;
    logic [`XLEN-1:0]   memWdata;
    logic [`XLEN-1:0]   memRdata;
    logic               memStall;
    logic [`XLEN-1:0]   debugWbPc;
    logic [3:0]         debugWbRfWen;
    logic [`REG_AW-1:0] debugWbRfWnum;
    logic [`XLEN-1:0]   debugWbRfWdata;

    int               kindArr [ProgLen];
    logic [4:0]       rsArr [ProgLen];
    logic [4:0]       rtArr [ProgLen];
    logic [4:0]       rdArr [ProgLen];
    logic [31:0]      immArr [ProgLen];   // imm, shamt, branch offset or jump index
    logic [31:0]      progMem [ProgLen];
    logic [31:0]      mem [MemWords];     // memory seen by the DUT
    logic [31:0]      refMem [MemWords];
    logic [31:0]      refRegs [32];
    logic [31:0]      expPc [ProgLen];
    logic [4:0]       expReg [ProgLen];
    logic [31:0]      expData [ProgLen];
    int               expCount;
    int               refStores;
    int               commitIdx;
    int               storeCount;
    int               errorsRun;
    int               errorsEnd;

    cpuTop i_cpuTop (
        .clk, .reset, .memEn, .memWen, .memAddr, .memWdata, .memRdata, .memStall,
        .debugWbPc, .debugWbRfWen, .debugWbRfWnum, .debugWbRfWdata
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign memRdata = mem[memAddr[10:2]];   // same-cycle answer

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
    endfunction

    function automatic logic [31:0] sext16(input logic [31:0] x);
        return {{16{x[15]}}, x[15:0]};
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old,
                                               input logic [31:0] wdata,
                                               input logic [3:0] wen);
        logic [31:0] res;
        int k;
        res = old;
        for (k = 0; k < 4; k++)
            if (wen[k])
                res[8*k +: 8] = wdata[8*k +: 8];
        return res;
    endfunction

    function automatic logic [31:0] encodeInstr(input int kind, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [4:0] rd,
                                                input logic [31:0] imm);
        logic [5:0] fn;
        logic [5:0] op;
        fn = `FN_SLL;
        op = `OP_SPECIAL;
        case (kind)
            kAddu:  fn = `FN_ADDU;
            kSubu:  fn = `FN_SUBU;
            kAnd:   fn = `FN_AND;
            kOr:    fn = `FN_OR;
            kXor:   fn = `FN_XOR;
            kSlt:   fn = `FN_SLT;
            kAddiu: op = `OP_ADDIU;
            kOri:   op = `OP_ORI;
            kLui:   op = `OP_LUI;
            kLw:    op = `OP_LW;
            kLb:    op = `OP_LB;
            kSw:    op = `OP_SW;
            kSb:    op = `OP_SB;
            kBeq:   op = `OP_BEQ;
            kBne:   op = `OP_BNE;
            default: ;
        endcase
        if (kind == kJ)
            return {`OP_J, imm[25:0]};
        if (kind <= kSll)
            return {`OP_SPECIAL, rs, rt, rd, (kind == kSll) ? imm[4:0] : 5'd0, fn};
        return {op, rs, rt, imm[15:0]};
    endfunction

    task automatic printMismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("** Error %s: expected %h actual %h", name, expected, actual);
    endtask

    task automatic buildProgram();
        int i;
        int span;
        for (i = 0; i < ProgLen - 1; i++) begin
            kindArr[i] = int'($urandom % kCount);
            rsArr[i]   = 5'($urandom % 8);   // r0-r7 keeps dependencies dense
            rtArr[i]   = 5'($urandom % 8);
            rdArr[i]   = 5'($urandom % 8);
            immArr[i]  = $urandom;
            span       = (ProgLen - 2 - i > 4) ? 4 : ProgLen - 2 - i;
            case (kindArr[i])
                kSll, kLui: rsArr[i] = 5'd0;
                kLw, kSw: begin
                    rsArr[i]  = 5'd0;
                    immArr[i] = 32'h400 + 4 * ($urandom % 32);
                end
                kLb, kSb: begin
                    rsArr[i]  = 5'd0;
                    immArr[i] = 32'h400 + ($urandom % 128);
                end
                kBeq, kBne: immArr[i] = $urandom % (span + 1);     // forward only
                kJ:         immArr[i] = i + 1 + ($urandom % (span + 1));
                default: ;
            endcase
            progMem[i] = encodeInstr(kindArr[i], rsArr[i], rtArr[i], rdArr[i], immArr[i]);
        end
        kindArr[ProgLen-1] = kJ;
        immArr[ProgLen-1]  = ProgLen - 1;
        progMem[ProgLen-1] = encodeInstr(kJ, 5'd0, 5'd0, 5'd0, immArr[ProgLen-1]);
    endtask

    // ISA-level stepper without delay slots
    task automatic runModel();
        int pc;
        int nextPc;
        int w;
        int sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [4:0]  dest;
        logic        wr;
        for (w = 0; w < MemWords; w++)
            refMem[w] = (w < ProgLen) ? progMem[w] : fillWord(32'(w * 4));
        for (w = 0; w < 32; w++)
            refRegs[w] = '0;
        pc        = 0;
        expCount  = 0;
        refStores = 0;
        while (pc != ProgLen - 1) begin
            a      = refRegs[rsArr[pc]];
            b      = refRegs[rtArr[pc]];
            addr   = a + sext16(immArr[pc]);
            w      = int'(addr[10:2]);
            sh     = 8 * int'(addr[1:0]);
            dest   = (kindArr[pc] <= kSll) ? rdArr[pc] : rtArr[pc];
            wr     = 1'b1;
            res    = '0;
            nextPc = pc + 1;
            case (kindArr[pc])
                kAddu:  res = a + b;
                kSubu:  res = a - b;
                kAnd:   res = a & b;
                kOr:    res = a | b;
                kXor:   res = a ^ b;
                kSlt:   res = {31'b0, $signed(a) < $signed(b)};
                kSll:   res = b << immArr[pc][4:0];
                kAddiu: res = a + sext16(immArr[pc]);
                kOri:   res = a | {16'h0000, immArr[pc][15:0]};
                kLui:   res = {immArr[pc][15:0], 16'h0000};
                kLw:    res = refMem[w];
                kLb:    res = {24'b0, 8'(refMem[w] >> sh)};
                kSw: begin
                    wr        = 1'b0;
                    refMem[w] = b;
                    refStores++;
                end
                kSb: begin
                    wr        = 1'b0;
                    refMem[w] = (refMem[w] & ~(32'hff << sh)) | ({24'b0, b[7:0]} << sh);
                    refStores++;
                end
                kBeq, kBne: begin
                    wr = 1'b0;
                    if ((a == b) == (kindArr[pc] == kBeq))
                        nextPc = pc + 1 + int'(immArr[pc][15:0]);
                end
                default: begin
                    wr     = 1'b0;
                    nextPc = int'(immArr[pc][25:0]);
                end
            endcase
            if (kindArr[pc] == kLb)
                res = {{24{res[7]}}, res[7:0]};   // byte sign extension
            if (wr) begin
                expPc[expCount]   = 32'(pc * 4);
                expReg[expCount]  = dest;
                expData[expCount] = res;
                expCount++;
                if (dest != 5'd0)
                    refRegs[dest] = res;
            end
            pc = nextPc;
        end
    endtask

    always @(posedge clk) begin : monitor
        int w;
        if (reset) begin
            for (w = 0; w < MemWords; w++)
                mem[w] <= (w < ProgLen) ? progMem[w] : fillWord(32'(w * 4));
            commitIdx  = 0;
            storeCount = 0;
            errorsRun  = 0;
        end else begin
            if (memEn && memWen != 4'b0000 && !memStall) begin
                mem[memAddr[10:2]] <= mergeBytes(mem[memAddr[10:2]], memWdata, memWen);
                storeCount++;
            end
            if (debugWbRfWen != 4'b0000) begin
                if (memStall) begin
                    errorsRun++;
                    $display("commit at pc %h appeared while memStall was high", debugWbPc);
                end
                if (commitIdx >= expCount) begin
                    errorsRun++;
                    $display("unexpected commit past the end of the trace, pc %h", debugWbPc);
                end else begin
                    if (debugWbPc !== expPc[commitIdx]) begin
                        errorsRun++;
                        printMismatch($sformatf("commit %0d pc", commitIdx),
                                      expPc[commitIdx], debugWbPc);
                    end
                    if (debugWbRfWnum !== expReg[commitIdx]) begin
                        errorsRun++;
                        printMismatch($sformatf("commit %0d reg", commitIdx),
                                      {27'b0, expReg[commitIdx]}, {27'b0, debugWbRfWnum});
                    end
                    if (debugWbRfWdata !== expData[commitIdx]) begin
                        errorsRun++;
                        printMismatch($sformatf("commit %0d data", commitIdx),
                                      expData[commitIdx], debugWbRfWdata);
                    end
                    commitIdx++;
                end
            end
        end
    end

    initial begin : mainFlow
        int cycles;
        int i;
        void'($urandom(32'h768fdf1c));
        reset     = 1'b1;
        memStall  = 1'b0;
        errorsEnd = 0;
        buildProgram();
        runModel();

        for (i = 0; i < 8; i++) begin
            @(posedge clk);
            @(negedge clk);
            if (memEn !== 1'b0) begin
                errorsEnd++;
                printMismatch("reset memEn", 32'h0, {31'b0, memEn});
            end
            if (debugWbRfWen !== 4'b0000) begin
                errorsEnd++;
                printMismatch("reset debugWbRfWen", 32'h0, {28'b0, debugWbRfWen});
            end
        end
        reset = 1'b0;

        cycles = 0;
        while ((commitIdx < expCount || storeCount < refStores) && cycles < RunTimeout) begin
            @(negedge clk);
            memStall = ($urandom % 5) == 0;   // 20% stall
            cycles++;
        end
        if (commitIdx < expCount || storeCount < refStores) begin
            errorsEnd++;
            $display("timeout after %0d cycles with %0d of %0d commits and %0d of %0d stores",
                     cycles, commitIdx, expCount, storeCount, refStores);
        end

        // spin on the self-jump where nothing more may commit or store
        memStall = 1'b0;
        for (i = 0; i < DrainCycles; i++)
            @(negedge clk);
        if (storeCount != refStores) begin
            errorsEnd++;
            printMismatch("store count", 32'(refStores), 32'(storeCount));
        end
        for (i = DataBase; i < MemWords; i++) begin
            if (mem[i] !== refMem[i]) begin
                errorsEnd++;
                printMismatch($sformatf("data word %h", i * 4), refMem[i], mem[i]);
            end
        end

        $display("commits %0d of %0d, stores %0d of %0d, errors %0d",
                 commitIdx, expCount, storeCount, refStores, errorsRun + errorsEnd);
        if (errorsRun + errorsEnd == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end
endmodule

/* sources.f */
+incdir+verilog
verilog/cpuPkg.sv
verilog/memBusIf.sv
verilog/fetchUnit.sv
verilog/decodeUnit.sv
verilog/executeUnit.sv
verilog/memStage.sv
verilog/busArbiter.sv
verilog/hazardUnit.sv
verilog/cpuTop.sv
sim/cpuTb.sv

/* verilog/busArbiter.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

module busArbiter (
    memBusIf.arbiter         fetchBus,
    memBusIf.arbiter         dataBus,
    output logic             memEn,
    output logic [3:0]       memWen,
    output logic [`XLEN-1:0] memAddr,
    output logic [`XLEN-1:0] memWdata,
    input  logic [`XLEN-1:0] memRdata,
    input  logic             memStall
);
    logic dataOwns;

    assign dataOwns = dataBus.en;   // data access always wins

    assign memEn    = dataOwns | fetchBus.en;
    assign memWen   = dataOwns ? dataBus.wen : fetchBus.wen;
    assign memAddr  = dataOwns ? dataBus.addr : fetchBus.addr;
    assign memWdata = dataOwns ? dataBus.wdata : fetchBus.wdata;

    assign fetchBus.rdata = memRdata;
    assign dataBus.rdata  = memRdata;

    // memory stall freezes the whole pipe, so the data side sees it too
    assign dataBus.stall  = memStall;
    assign fetchBus.stall = dataOwns | memStall;
endmodule

/* verilog/cpuCfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define XLEN      32
`define REG_COUNT 32
`define REG_AW    5
`define RESET_PC  32'h0000_0000

// primary opcodes
`define OP_SPECIAL 6'h00
`define OP_J       6'h02
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f
`define OP_LB      6'h20
`define OP_LW      6'h23
`define OP_SB      6'h28
`define OP_SW      6'h2b

// funct field under OP_SPECIAL
`define FN_SLL  6'h00
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_SLT  6'h2a

`endif

/* verilog/cpuPkg.sv */
`include "cpuCfg.svh"

package cpuPkg;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluLui
    } aluOpT;

    // none must stay at zero, a cleared ctrlT is a bubble
    typedef enum logic [2:0] {
        memNone, memLoadWord, memLoadByte, memStoreWord, memStoreByte
    } memOpT;

    typedef enum logic [1:0] {
        brNone, brBeq, brBne, brJump
    } branchOpT;

    typedef enum logic {
        fwdReg, fwdMem
    } fwdSelT;

    typedef struct packed {
        aluOpT              aluOp;
        memOpT              memOp;
        branchOpT           branchOp;
        logic               useImm;    // alu operand b from immediate
        logic               signExt;
        logic               regWrite;
        logic [`REG_AW-1:0] destReg;
    } ctrlT;

endpackage

/* verilog/cpuTop.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

module cpuTop (
    input  logic               clk,
    input  logic               reset,
    output logic               memEn,
    output logic [3:0]         memWen,
    output logic [`XLEN-1:0]   memAddr,
    output logic [`XLEN-1:0]   memWdata,
    input  logic [`XLEN-1:0]   memRdata,
    input  logic               memStall,
    output logic [`XLEN-1:0]   debugWbPc,
    output logic [3:0]         debugWbRfWen,
    output logic [`REG_AW-1:0] debugWbRfWnum,
    output logic [`XLEN-1:0]   debugWbRfWdata
);
    logic [`XLEN-1:0]   instrD;
    logic [`XLEN-1:0]   pcD;
    logic               validD;
    logic [`REG_AW-1:0] rsE;
    logic [`REG_AW-1:0] rtE;
    logic [`XLEN-1:0]   rd1E;
    logic [`XLEN-1:0]   rd2E;
    logic [`XLEN-1:0]   immE;
    logic [`XLEN-1:0]   pcE;
    cpuPkg::ctrlT       ctrlE;
    logic               validE;
    logic               redirect;
    logic [`XLEN-1:0]   redirectPc;
    logic [`XLEN-1:0]   resultM;
    logic [`XLEN-1:0]   storeDataM;
    logic [`XLEN-1:0]   pcM;
    cpuPkg::ctrlT       ctrlM;
    logic               validM;
    logic               memStallM;
    logic [`XLEN-1:0]   fwdData;
    logic               wbEn;
    logic [`REG_AW-1:0] wbAddr;
    logic [`XLEN-1:0]   wbData;
    logic               stallPipe;
    logic               loadUseStall;
    logic               flushRedirect;
    cpuPkg::fwdSelT     fwdSelA;
    cpuPkg::fwdSelT     fwdSelB;

    memBusIf fetchBus ();
    memBusIf dataBus ();

    fetchUnit i_fetchUnit (
        .clk, .reset, .bus(fetchBus), .stallPipe, .loadUseStall, .flushRedirect,
        .redirectPc, .instrD, .pcD, .validD
    );

    decodeUnit i_decodeUnit (
        .clk, .reset, .instrD, .pcD, .validD, .stallPipe, .loadUseStall, .flushRedirect,
        .wbEn, .wbAddr, .wbData, .rsE, .rtE, .rd1E, .rd2E, .immE, .pcE, .ctrlE, .validE
    );

    executeUnit i_executeUnit (
        .clk, .reset, .rd1E, .rd2E, .immE, .pcE, .ctrlE, .validE, .fwdSelA, .fwdSelB,
        .fwdData, .stallPipe, .redirect, .redirectPc, .resultM, .storeDataM, .pcM,
        .ctrlM, .validM
    );

    memStage i_memStage (
        .clk, .reset, .bus(dataBus), .resultM, .storeDataM, .ctrlM, .validM, .pcM,
        .memStallOut(memStallM), .fwdData, .wbEn, .wbAddr, .wbData,
        .debugWbPc, .debugWbRfWen, .debugWbRfWnum, .debugWbRfWdata
    );

    busArbiter i_busArbiter (
        .fetchBus(fetchBus), .dataBus(dataBus),
        .memEn, .memWen, .memAddr, .memWdata, .memRdata, .memStall
    );

    hazardUnit i_hazardUnit (
        .clk, .rsE, .rtE, .ctrlM, .validM,
        .rsD(instrD[25:21]), .rtD(instrD[20:16]),    // raw source fields of decode
        .ctrlE, .redirect, .memStallIn(memStallM),
        .stallPipe, .loadUseStall, .flushRedirect, .fwdSelA, .fwdSelB
    );
endmodule

/* verilog/decodeUnit.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

module decodeUnit (
    input  logic               clk,
    input  logic               reset,
    input  logic [`XLEN-1:0]   instrD,
    input  logic [`XLEN-1:0]   pcD,
    input  logic               validD,
    input  logic               stallPipe,
    input  logic               loadUseStall,
    input  logic               flushRedirect,
    input  logic               wbEn,
    input  logic [`REG_AW-1:0] wbAddr,
    input  logic [`XLEN-1:0]   wbData,
    output logic [`REG_AW-1:0] rsE,
    output logic [`REG_AW-1:0] rtE,
    output logic [`XLEN-1:0]   rd1E,
    output logic [`XLEN-1:0]   rd2E,
    output logic [`XLEN-1:0]   immE,
    output logic [`XLEN-1:0]   pcE,
    output cpuPkg::ctrlT       ctrlE,
    output logic               validE
);
    logic [5:0]         opcode;
    logic [5:0]         funct;
    logic [`REG_AW-1:0] rsD;
    logic [`REG_AW-1:0] rtD;
    logic [`XLEN-1:0]   immD;
    logic [`XLEN-1:0]   rd1D;
    logic [`XLEN-1:0]   rd2D;
    cpuPkg::ctrlT       ctrlD;
    logic [`XLEN-1:0]   regs [`REG_COUNT];

    assign opcode = instrD[31:26];
    assign funct  = instrD[5:0];
    assign rsD    = instrD[25:21];
    assign rtD    = instrD[20:16];

    always_comb begin
        ctrlD         = '0;   // anything not listed runs as a no-op
        ctrlD.signExt = 1'b1;
        ctrlD.destReg = rtD;
        case (opcode)
            `OP_SPECIAL: begin
                ctrlD.destReg  = instrD[15:11];
                ctrlD.regWrite = 1'b1;
                case (funct)
                    `FN_ADDU: ctrlD.aluOp = cpuPkg::aluAdd;
                    `FN_SUBU: ctrlD.aluOp = cpuPkg::aluSub;
                    `FN_AND:  ctrlD.aluOp = cpuPkg::aluAnd;
                    `FN_OR:   ctrlD.aluOp = cpuPkg::aluOr;
                    `FN_XOR:  ctrlD.aluOp = cpuPkg::aluXor;
                    `FN_SLT:  ctrlD.aluOp = cpuPkg::aluSlt;
                    `FN_SLL:  ctrlD.aluOp = cpuPkg::aluSll;
                    default:  ctrlD.regWrite = 1'b0;
                endcase
            end
            `OP_ADDIU: begin
                ctrlD.useImm   = 1'b1;
                ctrlD.regWrite = 1'b1;
            end
            `OP_ORI: begin
                ctrlD.aluOp    = cpuPkg::aluOr;
                ctrlD.useImm   = 1'b1;
                ctrlD.signExt  = 1'b0;
                ctrlD.regWrite = 1'b1;
            end
            `OP_LUI: begin
                ctrlD.aluOp    = cpuPkg::aluLui;
                ctrlD.useImm   = 1'b1;
                ctrlD.regWrite = 1'b1;
            end
            `OP_LW, `OP_LB: begin
                ctrlD.memOp    = (opcode == `OP_LW) ? cpuPkg::memLoadWord
                                                    : cpuPkg::memLoadByte;
                ctrlD.useImm   = 1'b1;
                ctrlD.regWrite = 1'b1;
            end
            `OP_SW, `OP_SB: begin
                ctrlD.memOp  = (opcode == `OP_SW) ? cpuPkg::memStoreWord
                                                  : cpuPkg::memStoreByte;
                ctrlD.useImm = 1'b1;
            end
            `OP_BEQ: ctrlD.branchOp = cpuPkg::brBeq;
            `OP_BNE: ctrlD.branchOp = cpuPkg::brBne;
            `OP_J:   ctrlD.branchOp = cpuPkg::brJump;
            default: ;
        endcase
    end

    always_comb begin
        if (ctrlD.branchOp == cpuPkg::brJump)
            immD = {4'b0000, instrD[25:0], 2'b00};   // pc[31:28] added in execute
        else if (ctrlD.signExt)
            immD = {{16{instrD[15]}}, instrD[15:0]};
        else
            immD = {16'h0000, instrD[15:0]};
    end

    function automatic logic [`XLEN-1:0] readReg(input logic [`REG_AW-1:0] addr);
        if (addr == '0)
            return '0;
        if (wbEn && wbAddr == addr)
            return wbData;      // write-through from commit
        return regs[addr];
    endfunction

    always_comb begin
        rd1D = readReg(rsD);
        rd2D = readReg(rtD);
    end

    always_ff @(posedge clk) begin
        if (wbEn && wbAddr != '0)
            regs[wbAddr] <= wbData;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validE <= 1'b0;
            ctrlE  <= '0;
        end else if (!stallPipe) begin
            if (flushRedirect || loadUseStall || !validD) begin
                validE <= 1'b0;
                ctrlE  <= '0;
            end else begin
                validE <= 1'b1;
                ctrlE  <= ctrlD;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stallPipe) begin
            rsE  <= rsD;
            rtE  <= rtD;
            rd1E <= rd1D;
            rd2E <= rd2D;
            immE <= immD;
            pcE  <= pcD;
        end
    end
endmodule

/* verilog/executeUnit.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

module executeUnit (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] rd1E,
    input  logic [`XLEN-1:0] rd2E,
    input  logic [`XLEN-1:0] immE,
    input  logic [`XLEN-1:0] pcE,
    input  cpuPkg::ctrlT     ctrlE,
    input  logic             validE,
    input  cpuPkg::fwdSelT   fwdSelA,
    input  cpuPkg::fwdSelT   fwdSelB,
    input  logic [`XLEN-1:0] fwdData,
    input  logic             stallPipe,
    output logic             redirect,
    output logic [`XLEN-1:0] redirectPc,
    output logic [`XLEN-1:0] resultM,
    output logic [`XLEN-1:0] storeDataM,
    output logic [`XLEN-1:0] pcM,
    output cpuPkg::ctrlT     ctrlM,
    output logic             validM
);
    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] regB;    // rt after forwarding
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluOut;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] branchTarget;
    logic [`XLEN-1:0] jumpTarget;
    logic             taken;

    assign srcA = (fwdSelA == cpuPkg::fwdMem) ? fwdData : rd1E;
    assign regB = (fwdSelB == cpuPkg::fwdMem) ? fwdData : rd2E;
    assign srcB = ctrlE.useImm ? immE : regB;

    // load/store address is the add path
    always_comb begin
        case (ctrlE.aluOp)
            cpuPkg::aluAdd: aluOut = srcA + srcB;
            cpuPkg::aluSub: aluOut = srcA - srcB;
            cpuPkg::aluAnd: aluOut = srcA & srcB;
            cpuPkg::aluOr:  aluOut = srcA | srcB;
            cpuPkg::aluXor: aluOut = srcA ^ srcB;
            cpuPkg::aluSlt: aluOut = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            cpuPkg::aluSll: aluOut = srcB << immE[10:6];
            default:        aluOut = {immE[15:0], 16'h0000};
        endcase
    end

    assign pcPlus4      = pcE + 32'd4;
    assign branchTarget = pcPlus4 + {immE[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], immE[27:0]};

    always_comb begin
        case (ctrlE.branchOp)
            cpuPkg::brBeq:  taken = (srcA == regB);
            cpuPkg::brBne:  taken = (srcA != regB);
            cpuPkg::brJump: taken = 1'b1;
            default:        taken = 1'b0;
        endcase
    end

    assign redirect   = validE & taken;
    assign redirectPc = (ctrlE.branchOp == cpuPkg::brJump) ? jumpTarget : branchTarget;

    always_ff @(posedge clk) begin
        if (reset) begin
            validM <= 1'b0;
            ctrlM  <= '0;
        end else if (!stallPipe) begin
            validM <= validE;
            ctrlM  <= ctrlE;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallPipe) begin
            resultM    <= aluOut;
            storeDataM <= regB;
            pcM        <= pcE;
        end
    end
endmodule

/* verilog/fetchUnit.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

module fetchUnit (
    input  logic             clk,
    input  logic             reset,
    memBusIf.client          bus,
    input  logic             stallPipe,
    input  logic             loadUseStall,
    input  logic             flushRedirect,
    input  logic [`XLEN-1:0] redirectPc,
    output logic [`XLEN-1:0] instrD,
    output logic [`XLEN-1:0] pcD,
    output logic             validD
);
    logic [`XLEN-1:0] pc;
    logic             fetchOn;
    logic             fetchOk;

    assign bus.en    = fetchOn;
    assign bus.wen   = 4'b0000;
    assign bus.addr  = pc;
    assign bus.wdata = '0;
    assign fetchOk   = fetchOn & ~bus.stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= `RESET_PC;
            fetchOn <= 1'b0;
            validD  <= 1'b0;
        end else begin
            fetchOn <= 1'b1;    // first request the cycle after reset
            if (flushRedirect) begin
                pc     <= redirectPc;
                validD <= 1'b0;     // drops the wrong-path fetch
            end else if (!stallPipe && !loadUseStall) begin
                pc     <= fetchOk ? pc + 32'd4 : pc;
                validD <= fetchOk;  // refused fetch is a bubble
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stallPipe && !loadUseStall && fetchOk) begin
            instrD <= bus.rdata;
            pcD    <= pc;
        end
    end

    // redirect targets and pc+4 both keep the fetch address on a word
    pcAligned: assert property (@(posedge clk) disable iff (reset)
        fetchOn |-> bus.addr[1:0] == 2'b00);
endmodule

/* verilog/hazardUnit.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

module hazardUnit (
    input  logic               clk,
    input  logic [`REG_AW-1:0] rsE,
    input  logic [`REG_AW-1:0] rtE,
    input  cpuPkg::ctrlT       ctrlM,
    input  logic               validM,
    input  logic [`REG_AW-1:0] rsD,
    input  logic [`REG_AW-1:0] rtD,
    input  cpuPkg::ctrlT       ctrlE,
    input  logic               redirect,
    input  logic               memStallIn,
    output logic               stallPipe,
    output logic               loadUseStall,
    output logic               flushRedirect,
    output cpuPkg::fwdSelT     fwdSelA,
    output cpuPkg::fwdSelT     fwdSelB
);
    logic mFwdOk;
    logic loadE;
    logic loadUseRaw;

    // load data arrives too late in M to forward
    assign mFwdOk = validM & ctrlM.regWrite & (ctrlM.destReg != '0)
                  & (ctrlM.memOp inside {cpuPkg::memNone, cpuPkg::memStoreWord,
                                         cpuPkg::memStoreByte});

    assign fwdSelA = (mFwdOk && ctrlM.destReg == rsE) ? cpuPkg::fwdMem : cpuPkg::fwdReg;
    assign fwdSelB = (mFwdOk && ctrlM.destReg == rtE) ? cpuPkg::fwdMem : cpuPkg::fwdReg;

    // a bubble in E carries a cleared ctrl
    assign loadE      = ctrlE.memOp inside {cpuPkg::memLoadWord, cpuPkg::memLoadByte};
    assign loadUseRaw = loadE & ctrlE.regWrite & (ctrlE.destReg != '0)
                      & (ctrlE.destReg == rsD || ctrlE.destReg == rtD);

    assign stallPipe     = memStallIn;
    assign loadUseStall  = loadUseRaw & ~stallPipe;
    assign flushRedirect = redirect & ~stallPipe;

    // a memory stall must not swallow a pending load-use bubble
    loadUseKept: assert property (@(posedge clk)
        (stallPipe && loadUseRaw) |=> loadUseRaw);
endmodule

/* verilog/memBusIf.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

interface memBusIf;
    logic             en;
    logic [3:0]       wen;     // byte lanes, zero for reads
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
    logic [`XLEN-1:0] rdata;
    logic             stall;

    modport client (output en, wen, addr, wdata, input rdata, stall);
    modport arbiter (input en, wen, addr, wdata, output rdata, stall);
endinterface

/* verilog/memStage.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

module memStage (
    input  logic               clk,
    input  logic               reset,
    memBusIf.client            bus,
    input  logic [`XLEN-1:0]   resultM,
    input  logic [`XLEN-1:0]   storeDataM,
    input  cpuPkg::ctrlT       ctrlM,
    input  logic               validM,
    input  logic [`XLEN-1:0]   pcM,
    output logic               memStallOut,
    output logic [`XLEN-1:0]   fwdData,
    output logic               wbEn,
    output logic [`REG_AW-1:0] wbAddr,
    output logic [`XLEN-1:0]   wbData,
    output logic [`XLEN-1:0]   debugWbPc,
    output logic [3:0]         debugWbRfWen,
    output logic [`REG_AW-1:0] debugWbRfWnum,
    output logic [`XLEN-1:0]   debugWbRfWdata
);
    logic       isLoad;
    logic       isStore;
    logic [3:0] laneMask;
    logic [7:0] loadByte;
    logic       commit;

    assign isLoad  = ctrlM.memOp inside {cpuPkg::memLoadWord, cpuPkg::memLoadByte};
    assign isStore = ctrlM.memOp inside {cpuPkg::memStoreWord, cpuPkg::memStoreByte};

    always_comb begin
        case (ctrlM.memOp)
            cpuPkg::memStoreWord: laneMask = 4'b1111;
            cpuPkg::memStoreByte: laneMask = 4'b0001 << resultM[1:0];
            default:              laneMask = 4'b0000;
        endcase
    end

    assign bus.en    = validM & (isLoad | isStore);
    assign bus.wen   = laneMask;
    assign bus.addr  = resultM;
    assign bus.wdata = (ctrlM.memOp == cpuPkg::memStoreByte) ? {4{storeDataM[7:0]}}
                                                             : storeDataM;

    assign loadByte = bus.rdata[{resultM[1:0], 3'b000} +: 8];
    assign wbData   = !isLoad ? resultM :
                      (ctrlM.memOp == cpuPkg::memLoadByte) ? {{24{loadByte[7]}}, loadByte}
                                                           : bus.rdata;

    assign commit      = validM & ctrlM.regWrite & ~bus.stall;
    assign wbEn        = commit;
    assign wbAddr      = ctrlM.destReg;
    assign fwdData     = resultM;     // hazard unit only picks this for non-loads
    assign memStallOut = bus.stall;

    assign debugWbPc      = pcM;
    assign debugWbRfWen   = {4{commit}};
    assign debugWbRfWnum  = ctrlM.destReg;
    assign debugWbRfWdata = wbData;

    noWriteWithoutEn: assert property (@(posedge clk) disable iff (reset)
        !bus.en |-> bus.wen == 4'b0000);
endmodule
